// File: fd_pkg.sv
package fd_pkg;

	localparam int FRAME_W = 8;                    // Frame width in pixels
	localparam int FRAME_H = 8;
	localparam int WIN = 4;                        // Window side
	localparam int HALF_WIN = WIN / 2;             // Side of one feature half
	localparam int NUM_WIN_X = FRAME_W - WIN + 1;  // Window positions per row
	localparam int NUM_WIN_Y = FRAME_H - WIN + 1;
	localparam int NUM_STAGE = 2;
	localparam int CLS_PER_STAGE = 2;
	localparam int NUM_CLS = NUM_STAGE * CLS_PER_STAGE;

	localparam int PIX_W = 8;
	localparam int COORD_W = $clog2(FRAME_W);
	localparam int II_W = 14;                      // Holds 64 pixels of 255
	localparam int SCORE_W = 12;
	localparam int CLS_W = $clog2(NUM_CLS);
	localparam int STAGE_W = $clog2(NUM_STAGE);
	localparam int CLS_SUB_W = $clog2(CLS_PER_STAGE);

	typedef logic [PIX_W-1:0] pixel_t;
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [2*COORD_W-1:0] ii_addr_t;       // Row then column
	typedef logic [II_W-1:0] ii_t;
	typedef logic signed [SCORE_W-1:0] score_t;
	typedef logic [CLS_W-1:0] cls_idx_t;

	typedef enum logic
	{
		FEAT_HORZ,                                 // Left half minus right half
		FEAT_VERT                                  // Top half minus bottom half
	} feat_kind_t;

	typedef struct packed
	{
		feat_kind_t kind;
		score_t     thr;                           // Node threshold
		score_t     pass_val;                      // Vote when feature >= thr
		score_t     fail_val;
	} haar_cls_t;

	// Stage s uses entries 2s and 2s+1
	localparam haar_cls_t CLS_TABLE [NUM_CLS] = '{
		'{FEAT_HORZ, 12'sd40, 12'sd4, -12'sd3},
		'{FEAT_VERT, -12'sd20, 12'sd2, -12'sd2},
		'{FEAT_VERT, 12'sd30, 12'sd5, -12'sd1},
		'{FEAT_HORZ, -12'sd200, 12'sd1, -12'sd6}
	};

	localparam score_t STAGE_THR [NUM_STAGE] = '{
		12'sd1,
		12'sd0
	};

endpackage

// File: fd_ifs.sv
`timescale 1ns/1ns

// Rectangle-sum read port into the integral image
interface integral_rd_if;

	fd_pkg::coord_t rx0;
	fd_pkg::coord_t ry0;
	fd_pkg::coord_t rx1;
	fd_pkg::coord_t ry1;
	fd_pkg::ii_t    rsum;                  // Same-cycle answer

	modport mem  (input rx0, ry0, rx1, ry1, output rsum);
	modport user (output rx0, ry0, rx1, ry1, input rsum);

endinterface

// Classifier request from the FSM to the feature evaluator
interface haar_req_if;

	logic             req;
	fd_pkg::coord_t   win_x;
	fd_pkg::coord_t   win_y;
	fd_pkg::cls_idx_t cls_idx;
	logic             vote_valid;          // Two cycles after req
	fd_pkg::score_t   vote;

	modport ctrl
	(
		output req, win_x, win_y, cls_idx,
		input  vote_valid, vote
	);
	modport eval
	(
		input  req, win_x, win_y, cls_idx,
		output vote_valid, vote
	);

endinterface

// File: integral_image.sv
`timescale 1ns/1ns

module integral_image
(
	input  logic           clk_os,
	input  logic           rst_n,
	input  logic           pixel_valid,
	input  fd_pkg::pixel_t pixel,
	input  logic           scan_active,
	output logic           frame_full,
	integral_rd_if.mem     rd
);

	fd_pkg::ii_t      ii_mem [fd_pkg::FRAME_W * fd_pkg::FRAME_H];
	fd_pkg::coord_t   pos_x;
	fd_pkg::coord_t   pos_y;
	logic             accept;
	logic             last_pos;
	logic             wr_en;
	fd_pkg::coord_t   wr_x;
	fd_pkg::coord_t   wr_y;
	fd_pkg::ii_addr_t wr_addr;
	fd_pkg::pixel_t   pix_q;
	fd_pkg::ii_t      row_sum;                  // Sum of the current row so far
	fd_pkg::ii_t      row_next;
	fd_pkg::ii_t      above;
	fd_pkg::ii_t      s_br;
	fd_pkg::ii_t      s_bl;
	fd_pkg::ii_t      s_tr;
	fd_pkg::ii_t      s_tl;

	assign accept   = pixel_valid && !scan_active;  // Dropped during a scan
	assign last_pos = (pos_x == fd_pkg::FRAME_W - 1) && (pos_y == fd_pkg::FRAME_H - 1);

	always_ff @(posedge clk_os or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pos_x      <= '0;
			pos_y      <= '0;
			wr_en      <= 1'b0;
			frame_full <= 1'b0;
		end
		else
		begin
			wr_en      <= accept;
			frame_full <= accept && last_pos;
			if (accept)
			begin
				if (pos_x == fd_pkg::FRAME_W - 1)
				begin
					pos_x <= '0;
					pos_y <= last_pos ? '0 : pos_y + 1'b1;  // Wrap for the next frame
				end
				else
					pos_x <= pos_x + 1'b1;
			end
		end
	end

	assign wr_addr  = {wr_y, wr_x};
	assign row_next = ((wr_x == '0) ? '0 : row_sum) + fd_pkg::ii_t'(pix_q);
	assign above    = (wr_y == '0) ? '0 : ii_mem[{wr_y - 1'b1, wr_x}];

	// Write stage, one cycle behind the pixel strobe
	always_ff @(posedge clk_os)
	begin
		if (accept)
		begin
			pix_q <= pixel;
			wr_x  <= pos_x;
			wr_y  <= pos_y;
		end
		if (wr_en)
		begin
			row_sum         <= row_next;
			ii_mem[wr_addr] <= row_next + above;
		end
	end

	// Four-corner rectangle sum, corners left of or above the frame read as zero
	assign s_br = ii_mem[{rd.ry1, rd.rx1}];
	assign s_bl = (rd.rx0 == '0) ? '0 : ii_mem[{rd.ry1, rd.rx0 - 1'b1}];
	assign s_tr = (rd.ry0 == '0) ? '0 : ii_mem[{rd.ry0 - 1'b1, rd.rx1}];
	assign s_tl = (rd.rx0 == '0 || rd.ry0 == '0) ? '0 : ii_mem[{rd.ry0 - 1'b1, rd.rx0 - 1'b1}];
	assign rd.rsum = s_br - s_bl - s_tr + s_tl;  // Wraps back into range

endmodule

// File: scan_counter.sv
`timescale 1ns/1ns

module scan_counter
(
	input  logic             clk_os,
	input  logic             rst_n,
	input  logic             clear,
	input  logic             step_cls,
	input  logic             next_stage,
	input  logic             next_win,
	output fd_pkg::coord_t   win_x,
	output fd_pkg::coord_t   win_y,
	output fd_pkg::cls_idx_t cls_idx,
	output logic             last_in_stage,
	output logic             last_stage,
	output logic             last_win
);

	logic [fd_pkg::STAGE_W-1:0]   stage;
	logic [fd_pkg::CLS_SUB_W-1:0] sub;       // Classifier within the stage

	always_ff @(posedge clk_os or negedge rst_n)
	begin
		if (!rst_n)
		begin
			win_x <= '0;
			win_y <= '0;
			stage <= '0;
			sub   <= '0;
		end
		else if (clear)
		begin
			win_x <= '0;
			win_y <= '0;
			stage <= '0;
			sub   <= '0;
		end
		else if (next_win)
		begin
			stage <= '0;
			sub   <= '0;
			if (win_x == fd_pkg::NUM_WIN_X - 1)
			begin
				win_x <= '0;
				win_y <= (win_y == fd_pkg::NUM_WIN_Y - 1) ? '0 : win_y + 1'b1;
			end
			else
				win_x <= win_x + 1'b1;
		end
		else if (next_stage)
		begin
			stage <= stage + 1'b1;
			sub   <= '0;                              // First classifier of next stage
		end
		else if (step_cls)
			sub <= sub + 1'b1;
	end

	assign cls_idx = fd_pkg::cls_idx_t'(stage * fd_pkg::CLS_PER_STAGE + sub);

	assign last_in_stage = (sub == fd_pkg::CLS_PER_STAGE - 1);
	assign last_stage    = (stage == fd_pkg::NUM_STAGE - 1);
	assign last_win      = (win_x == fd_pkg::NUM_WIN_X - 1) && (win_y == fd_pkg::NUM_WIN_Y - 1);

endmodule

// File: haar_feature_eval.sv
`timescale 1ns/1ns

module haar_feature_eval
(
	input  logic        clk_os,
	input  logic        rst_n,
	haar_req_if.eval    req,
	integral_rd_if.user rd
);

	logic              phase_a;                     // Reading rect A
	logic              phase_b;                     // Reading rect B, vote out
	fd_pkg::coord_t    x_q;
	fd_pkg::coord_t    y_q;
	fd_pkg::cls_idx_t  cls_q;
	fd_pkg::ii_t       sum_a;
	fd_pkg::haar_cls_t cls;
	fd_pkg::coord_t    a_x0, a_y0, a_x1, a_y1;
	fd_pkg::coord_t    b_x0, b_y0, b_x1, b_y1;
	fd_pkg::score_t    diff;

	assign cls = fd_pkg::CLS_TABLE[cls_q];

	// Split the window into two halves along the feature axis
	always_comb
	begin
		a_x0 = x_q;
		a_y0 = y_q;
		b_x1 = fd_pkg::coord_t'(x_q + fd_pkg::WIN - 1);
		b_y1 = fd_pkg::coord_t'(y_q + fd_pkg::WIN - 1);
		if (cls.kind == fd_pkg::FEAT_HORZ)
		begin
			a_x1 = fd_pkg::coord_t'(x_q + fd_pkg::HALF_WIN - 1);
			a_y1 = b_y1;
			b_x0 = fd_pkg::coord_t'(x_q + fd_pkg::HALF_WIN);
			b_y0 = y_q;
		end
		else
		begin
			a_x1 = b_x1;
			a_y1 = fd_pkg::coord_t'(y_q + fd_pkg::HALF_WIN - 1);
			b_x0 = x_q;
			b_y0 = fd_pkg::coord_t'(y_q + fd_pkg::HALF_WIN);
		end
	end

	assign rd.rx0 = phase_b ? b_x0 : a_x0;
	assign rd.ry0 = phase_b ? b_y0 : a_y0;
	assign rd.rx1 = phase_b ? b_x1 : a_x1;
	assign rd.ry1 = phase_b ? b_y1 : a_y1;

	assign diff = fd_pkg::score_t'(sum_a) - fd_pkg::score_t'(rd.rsum);  // Half sums fit in 11 bits
	assign req.vote_valid = phase_b;
	assign req.vote = ($signed(diff) >= $signed(cls.thr)) ? cls.pass_val : cls.fail_val;

	always_ff @(posedge clk_os or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase_a <= 1'b0;
			phase_b <= 1'b0;
		end
		else
		begin
			phase_a <= req.req;
			phase_b <= phase_a;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (req.req)
		begin
			x_q   <= req.win_x;
			y_q   <= req.win_y;
			cls_q <= req.cls_idx;
		end
		if (phase_a)
			sum_a <= rd.rsum;
	end

endmodule

// File: cascade_fsm.sv
`timescale 1ns/1ns

module cascade_fsm
(
	input  logic             clk_os,
	input  logic             rst_n,
	input  logic             frame_full,
	output logic             scan_active,
	haar_req_if.ctrl         req,
	output logic             clear,
	output logic             step_cls,
	output logic             next_stage,
	output logic             next_win,
	input  fd_pkg::coord_t   win_x,
	input  fd_pkg::coord_t   win_y,
	input  fd_pkg::cls_idx_t cls_idx,
	input  logic             last_in_stage,
	input  logic             last_stage,
	input  logic             last_win,
	output logic             busy,
	output logic             det_valid,
	output fd_pkg::coord_t   det_x,
	output fd_pkg::coord_t   det_y,
	output logic             scan_done
);

	typedef enum logic [2:0]
	{
		IDLE,
		ISSUE,
		WAIT,
		JUDGE,
		DONE
	} state_t;

	state_t         state;
	state_t         state_next;
	fd_pkg::score_t stage_sum;                       // Votes of the current stage
	logic           stage_pass;
	logic           detect;

	assign req.req     = (state == ISSUE);
	assign req.win_x   = win_x;
	assign req.win_y   = win_y;
	assign req.cls_idx = cls_idx;

	assign stage_pass = $signed(stage_sum) >=
		$signed(fd_pkg::STAGE_THR[cls_idx / fd_pkg::CLS_PER_STAGE]);
	assign detect     = (state == JUDGE) && stage_pass && last_stage;

	assign clear      = (state == IDLE) && frame_full;
	assign step_cls   = (state == WAIT) && req.vote_valid && !last_in_stage;
	assign next_stage = (state == JUDGE) && stage_pass && !last_stage;
	assign next_win   = (state == JUDGE) && !next_stage;  // Rejected or detected

	assign busy        = (state != IDLE);
	assign scan_active = busy || frame_full;           // Covers the cycle before the scan

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (frame_full)
					state_next = ISSUE;
			ISSUE:
				state_next = WAIT;
			WAIT:
				if (req.vote_valid)
					state_next = last_in_stage ? JUDGE : ISSUE;
			JUDGE:
				if (next_win && last_win)
					state_next = DONE;
				else
					state_next = ISSUE;
			DONE:
				state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk_os or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			stage_sum <= '0;
			det_valid <= 1'b0;
			scan_done <= 1'b0;
		end
		else
		begin
			state     <= state_next;
			det_valid <= detect;
			scan_done <= (state == DONE);             // Lands in the first idle cycle
			if (clear || state == JUDGE)
				stage_sum <= '0;
			else if (state == WAIT && req.vote_valid)
				stage_sum <= stage_sum + req.vote;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (detect)
		begin
			det_x <= win_x;
			det_y <= win_y;
		end
	end

endmodule

// File: face_detect_top.sv
`timescale 1ns/1ns

module face_detect_top
(
	input  logic           clk_os,
	input  logic           rst_n,
	input  logic           pixel_valid,
	input  fd_pkg::pixel_t pixel,
	output logic           busy,
	output logic           det_valid,
	output fd_pkg::coord_t det_x,
	output fd_pkg::coord_t det_y,
	output logic           scan_done
);

	integral_rd_if rd_if ();
	haar_req_if    req_if ();

	logic             frame_full;
	logic             scan_active;
	logic             clear;
	logic             step_cls;
	logic             next_stage;
	logic             next_win;
	fd_pkg::coord_t   win_x;
	fd_pkg::coord_t   win_y;
	fd_pkg::cls_idx_t cls_idx;
	logic             last_in_stage;
	logic             last_stage;
	logic             last_win;

	integral_image u_integral_image
	(
		.clk_os      (clk_os),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.scan_active (scan_active),
		.frame_full  (frame_full),
		.rd          (rd_if.mem)
	);

	scan_counter u_scan_counter
	(
		.clk_os        (clk_os),
		.rst_n         (rst_n),
		.clear         (clear),
		.step_cls      (step_cls),
		.next_stage    (next_stage),
		.next_win      (next_win),
		.win_x         (win_x),
		.win_y         (win_y),
		.cls_idx       (cls_idx),
		.last_in_stage (last_in_stage),
		.last_stage    (last_stage),
		.last_win      (last_win)
	);

	haar_feature_eval u_haar_feature_eval
	(
		.clk_os (clk_os),
		.rst_n  (rst_n),
		.req    (req_if.eval),
		.rd     (rd_if.user)
	);

	cascade_fsm u_cascade_fsm
	(
		.clk_os        (clk_os),
		.rst_n         (rst_n),
		.frame_full    (frame_full),
		.scan_active   (scan_active),
		.req           (req_if.ctrl),
		.clear         (clear),
		.step_cls      (step_cls),
		.next_stage    (next_stage),
		.next_win      (next_win),
		.win_x         (win_x),
		.win_y         (win_y),
		.cls_idx       (cls_idx),
		.last_in_stage (last_in_stage),
		.last_stage    (last_stage),
		.last_win      (last_win),
		.busy          (busy),
		.det_valid     (det_valid),
		.det_x         (det_x),
		.det_y         (det_y),
		.scan_done     (scan_done)
	);

endmodule

// File: tb_face_model.svh
typedef fd_pkg::pixel_t frame_t [fd_pkg::FRAME_W * fd_pkg::FRAME_H];
typedef int ii_arr_t [fd_pkg::FRAME_H][fd_pkg::FRAME_W];

logic [31:0] lcg_state = 32'h3247;

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
	return lcg_state;
endfunction

function automatic ii_arr_t build_integral(input frame_t f);
	ii_arr_t ii;
	int x;
	int y;
	int row;
	for (y = 0; y < fd_pkg::FRAME_H; y++)
	begin
		row = 0;
		for (x = 0; x < fd_pkg::FRAME_W; x++)
		begin
			row += f[y * fd_pkg::FRAME_W + x];
			ii[y][x] = row + ((y > 0) ? ii[y-1][x] : 0);
		end
	end
	return ii;
endfunction

// Inclusive rectangle, corners outside the frame count as zero
function automatic int rect_sum(input ii_arr_t ii, input int x0, input int y0,
	input int x1, input int y1);
	int s;
	s = ii[y1][x1];
	if (x0 > 0)
		s -= ii[y1][x0-1];
	if (y0 > 0)
		s -= ii[y0-1][x1];
	if (x0 > 0 && y0 > 0)
		s += ii[y0-1][x0-1];
	return s;
endfunction

function automatic int feature_value(input ii_arr_t ii, input fd_pkg::feat_kind_t kind,
	input int wx, input int wy);
	int h;
	int w;
	h = fd_pkg::WIN / 2;
	w = fd_pkg::WIN - 1;
	if (kind == fd_pkg::FEAT_HORZ)
		return rect_sum(ii, wx, wy, wx+h-1, wy+w) - rect_sum(ii, wx+h, wy, wx+w, wy+w);
	return rect_sum(ii, wx, wy, wx+w, wy+h-1) - rect_sum(ii, wx, wy+h, wx+w, wy+w);
endfunction

function automatic bit window_detects(input ii_arr_t ii, input int wx, input int wy);
	int s;
	int k;
	int c;
	int sum;
	int feat;
	int thr;
	int stage_thr;
	for (s = 0; s < fd_pkg::NUM_STAGE; s++)
	begin
		sum = 0;
		for (k = 0; k < fd_pkg::CLS_PER_STAGE; k++)
		begin
			c = s * fd_pkg::CLS_PER_STAGE + k;
			feat = feature_value(ii, fd_pkg::CLS_TABLE[c].kind, wx, wy);
			thr = $signed(fd_pkg::CLS_TABLE[c].thr);
			if (feat >= thr)
				sum += $signed(fd_pkg::CLS_TABLE[c].pass_val);
			else
				sum += $signed(fd_pkg::CLS_TABLE[c].fail_val);
		end
		stage_thr = $signed(fd_pkg::STAGE_THR[s]);
		if (sum < stage_thr)
			return 1'b0;  // Early rejection
	end
	return 1'b1;
endfunction

// File: tb_face_detect.sv
`timescale 1ns/1ns

module tb_face_detect;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_PIX = fd_pkg::FRAME_W * fd_pkg::FRAME_H;
	localparam int NUM_WINDOWS = fd_pkg::NUM_WIN_X * fd_pkg::NUM_WIN_Y;
	localparam int SCAN_CYCLES = NUM_WINDOWS * fd_pkg::NUM_CLS * 3 + 100;  // Scan plus margin
	localparam int NUM_FRAMES = 7;
	localparam int RUN_CYCLES = NUM_FRAMES * (NUM_PIX + SCAN_CYCLES) + 50;

	logic           clk_os = 1'b0;
	logic           rst_n;
	logic           pixel_valid;
	fd_pkg::pixel_t pixel;
	logic           busy;
	logic           det_valid;
	fd_pkg::coord_t det_x;
	fd_pkg::coord_t det_y;
	logic           scan_done;

	fd_pkg::coord_t got_x [$];
	fd_pkg::coord_t got_y [$];
	fd_pkg::coord_t exp_x [$];
	fd_pkg::coord_t exp_y [$];
	int             done_count;

	`include "tb_face_model.svh"

	face_detect_top UUT
	(
		.clk_os      (clk_os),
		.rst_n       (rst_n),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.busy        (busy),
		.det_valid   (det_valid),
		.det_x       (det_x),
		.det_y       (det_y),
		.scan_done   (scan_done)
	);

	always #(CLK_PERIOD / 2) clk_os = ~clk_os;

	// Outputs are stable at the falling edge
	always @(negedge clk_os)
	begin
		if (rst_n && det_valid)
		begin
			got_x.push_back(det_x);
			got_y.push_back(det_y);
		end
		if (rst_n && scan_done)
			done_count++;
	end

	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		abort_run();
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_coord(input string name, input fd_pkg::coord_t expected,
		input fd_pkg::coord_t actual);
		if (actual !== expected)
		begin
			$display("error %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected)
		begin
			$display("error %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("error %s: expected %b, actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic send_frame(input frame_t f);
		int i;
		for (i = 0; i < NUM_PIX; i++)
		begin
			@(negedge clk_os);
			pixel_valid = 1'b1;
			pixel       = f[i];
		end
		@(negedge clk_os);
		pixel_valid = 1'b0;
		pixel       = '0;
	endtask

	task automatic wait_scan_done(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk_os);
		while (scan_done !== 1'b1 && cycles < SCAN_CYCLES)
		begin
			@(negedge clk_os);
			cycles++;
		end
		if (scan_done !== 1'b1)
		begin
			$display("%s: scan_done never arrived after the frame", name);
			abort_run();
		end
		check_bit({name, " busy at scan_done"}, 1'b0, busy);  // Drops with scan_done
	endtask

	task automatic start_frame(input frame_t f);
		ii_arr_t ii;
		int wx;
		int wy;
		got_x.delete();
		got_y.delete();
		exp_x.delete();
		exp_y.delete();
		done_count = 0;
		ii = build_integral(f);
		for (wy = 0; wy < fd_pkg::NUM_WIN_Y; wy++)
			for (wx = 0; wx < fd_pkg::NUM_WIN_X; wx++)
				if (window_detects(ii, wx, wy))
				begin
					exp_x.push_back(fd_pkg::coord_t'(wx));
					exp_y.push_back(fd_pkg::coord_t'(wy));
				end
	endtask

	task automatic finish_frame(input string name);
		int i;
		repeat (3) @(negedge clk_os);
		check_count({name, " detections"}, exp_x.size(), got_x.size());
		for (i = 0; i < exp_x.size(); i++)
		begin
			check_coord($sformatf("%s det_x[%0d]", name, i), exp_x[i], got_x[i]);
			check_coord($sformatf("%s det_y[%0d]", name, i), exp_y[i], got_y[i]);
		end
		check_count({name, " scan_done pulses"}, 1, done_count);
	endtask

	task automatic run_frame(input string name, input frame_t f);
		start_frame(f);
		send_frame(f);
		wait_scan_done(name);
		finish_frame(name);
	endtask

	task automatic test_reset_idle();
		int i;
		for (i = 0; i < 5; i++)
		begin
			@(negedge clk_os);
			check_bit("reset_idle busy", 1'b0, busy);
			check_bit("reset_idle det_valid", 1'b0, det_valid);
			check_bit("reset_idle scan_done", 1'b0, scan_done);
		end
	endtask

	task automatic test_flat_frame();
		frame_t f;
		int i;
		for (i = 0; i < NUM_PIX; i++)
			f[i] = 8'd100;
		run_frame("flat_frame", f);
		check_count("flat_frame no detections", 0, got_x.size());  // Stage 1 sums to -1
	endtask

	task automatic test_bright_left_dark_bottom();
		frame_t f;
		int x;
		int y;
		for (y = 0; y < fd_pkg::FRAME_H; y++)
			for (x = 0; x < fd_pkg::FRAME_W; x++)
				f[y * fd_pkg::FRAME_W + x] = fd_pkg::pixel_t'(((x < 4) ? 200 : 40) -
					((y >= 4) ? 30 : 0));
		run_frame("bright_left", f);
		check_count("bright_left window count", 15, got_x.size());  // Windows at x 1 to 3
	endtask

	task automatic test_random_frames();
		frame_t f;
		int k;
		int i;
		for (k = 0; k < 3; k++)
		begin
			for (i = 0; i < NUM_PIX; i++)
				f[i] = fd_pkg::pixel_t'(lcg_next() >> 24);
			run_frame($sformatf("random_frame_%0d", k), f);
		end
	endtask

	task automatic test_drop_while_busy();
		frame_t fa;
		frame_t fb;
		int i;
		int x;
		int y;
		int cycles;
		for (i = 0; i < NUM_PIX; i++)
			fa[i] = fd_pkg::pixel_t'(lcg_next() >> 24);
		for (y = 0; y < fd_pkg::FRAME_H; y++)
			for (x = 0; x < fd_pkg::FRAME_W; x++)
				fb[y * fd_pkg::FRAME_W + x] = fd_pkg::pixel_t'(((y < 4) ? 220 : 20) + 4 * x);
		start_frame(fa);
		send_frame(fa);
		cycles = 0;
		while (busy !== 1'b1 && cycles < 10)
		begin
			@(negedge clk_os);
			cycles++;
		end
		if (busy !== 1'b1)
		begin
			$display("busy never rose after a full frame was sent");
			abort_run();
		end
		for (i = 0; i < 10; i++)
		begin
			check_bit("drop_while_busy busy", 1'b1, busy);
			pixel_valid = 1'b1;                // Junk strobes during the scan
			pixel       = 8'hff;
			@(negedge clk_os);
		end
		pixel_valid = 1'b0;
		pixel       = '0;
		wait_scan_done("drop_while_busy frame_a");
		finish_frame("drop_while_busy frame_a");
		run_frame("drop_while_busy frame_b", fb);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		pixel_valid = 1'b0;
		pixel       = '0;
		repeat (2) @(negedge clk_os);
		rst_n = 1'b1;
		test_reset_idle();
		test_flat_frame();
		test_bright_left_dark_bottom();
		test_random_frames();
		test_drop_while_busy();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
fd_pkg.sv
fd_ifs.sv
integral_image.sv
scan_counter.sv
haar_feature_eval.sv
cascade_fsm.sv
face_detect_top.sv
tb_face_detect.sv

// File: Bender.yml
package:
  name: face_detect

sources:
  - files:
      - fd_pkg.sv
      - fd_ifs.sv
      - integral_image.sv
      - scan_counter.sv
      - haar_feature_eval.sv
      - cascade_fsm.sv
      - face_detect_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_face_detect.sv
